// ==== design/st_mem_pkg.sv ====
// shared types and memory map constants for the st sdram request path
package st_mem_pkg;

	typedef logic [23:1] addr_t; // 68000 word address
	typedef logic [15:0] word_t;

	// ram size code from control bits 3:1
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_size_e;

	// gstmcu bus slot, cpu_pre comes right before the cpu slot
	typedef enum logic [1:0] {
		CYC_CPU_PRE = 2'd0,
		CYC_CPU     = 2'd1,
		CYC_VIKING  = 2'd2, // shared with the shifter
		CYC_OTHER   = 2'd3
	} bus_cycle_e;

	typedef struct packed {
		mem_size_e mem_size;
		logic      ste;
		logic      mste;
		logic      steroids;      // ste + mste together
		logic      viking_enable; // viking card usable in this config
	} st_cfg_t;

	// what the gstmcu would put on the chipset side
	typedef struct packed {
		logic       ras_n;
		logic       we_n;
		logic       uds;
		logic       lds;
		addr_t      ram_a;
		word_t      ram_din;
		addr_t      mbus_a;
		logic       rom_n;
		logic       rom2_n;   // tos rom area
		logic       as_n;
		logic       mhz8_en1;
		bus_cycle_e bus_cycle;
	} chip_bus_t;

	typedef struct packed {
		logic  strobe;   // toggles once per word
		logic  download;
		addr_t addr;
		word_t data;
	} upload_t;

	typedef struct packed {
		addr_t addr;
		word_t din;
		logic  uds;
		logic  lds;
		logic  we;
		logic  oe;
	} sdram_req_t;

	localparam logic [7:0] VIKING_ACCESS_MAX = 8'd255; // enough to trust the driver
	localparam logic [5:0] VIKING_ST_BASE    = 6'b110000; // $c0xxxx
	localparam logic [5:0] VIKING_HI_BASE    = 6'b111010; // $e8xxxx
	localparam logic [4:0] VIKING_HI_WIN     = 5'b11101;  // steroids video ram
	localparam logic [5:0] TOS192K_TAG       = 6'b111111; // $fc0000 upload
	localparam logic [3:0] TOS_E_TAG         = 4'he;
	localparam logic [5:0] ROM_E_PREFIX      = {4'he, 2'b00};
	localparam logic [5:0] ROM_F_PREFIX      = {4'hf, 2'b11};

endpackage

// ==== design/st_cfg_decode.sv ====
// configuration word decoder: ram size, machine type and viking enable
`timescale 1ns/1ps

module st_cfg_decode (
	input  logic [31:0]          system_ctrl_i,
	output st_mem_pkg::st_cfg_t  cfg_o
);

	import st_mem_pkg::*;

	mem_size_e mem_size;
	logic      ste;
	logic      mste;
	logic      steroids;
	logic      viking_req;
	logic      viking_mem_ok;

	assign mem_size = mem_size_e'(system_ctrl_i[3:1]);

	// machine type bits
	assign ste      = system_ctrl_i[23] | system_ctrl_i[24];
	assign mste     = system_ctrl_i[24];
	assign steroids = system_ctrl_i[23] & system_ctrl_i[24]; // ste on steroids

	assign viking_req = system_ctrl_i[28];

	// the $c0 window collides with ram above 8M
	assign viking_mem_ok = (mem_size <= MEM_8M);

	assign cfg_o.mem_size      = mem_size;
	assign cfg_o.ste           = ste;
	assign cfg_o.mste          = mste;
	assign cfg_o.steroids      = steroids;
	// steroids moves video ram to $e8, so any size goes
	assign cfg_o.viking_enable = (viking_req & viking_mem_ok) | steroids;

endmodule

// ==== design/st_upload_ctrl.sv ====
// upload strobe to write pulse conversion and tos 192k detection
`timescale 1ns/1ps

module st_upload_ctrl (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  st_mem_pkg::upload_t    upload_i,
	input  st_mem_pkg::bus_cycle_e bus_cycle_i,
	input  logic                   mhz8_en1_i,
	output logic                   data_wr_o,
	output logic                   tos192k_o
);

	import st_mem_pkg::*;

	logic strobe_d;   // last sampled toggle
	logic sample_en;

	// only look at the strobe in the slot before the cpu slot
	assign sample_en = (bus_cycle_i == CYC_CPU_PRE) & mhz8_en1_i;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			strobe_d  <= 1'b0;
			data_wr_o <= 1'b0;
		end else begin
			data_wr_o <= 1'b0; // single cycle pulse
			if (sample_en) begin
				strobe_d <= upload_i.strobe;
				if (upload_i.strobe ^ strobe_d)
					data_wr_o <= 1'b1; // lands in the cpu slot
			end
		end
	end

	// a 192k tos loads at $fc0000, a 256k one at $e00000
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k_o <= 1'b0;
		end else if (upload_i.download) begin
			if (upload_i.addr[23:18] == TOS192K_TAG)
				tos192k_o <= 1'b1;
			else if (upload_i.addr[23:20] == TOS_E_TAG)
				tos192k_o <= 1'b0;
		end
	end

endmodule

// ==== design/st_viking_detect.sv ====
// viking driver detection by counting framebuffer accesses
`timescale 1ns/1ps

module st_viking_detect (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  st_mem_pkg::st_cfg_t   cfg_i,
	input  st_mem_pkg::chip_bus_t bus_i,
	output logic                  viking_active_o
);

	import st_mem_pkg::*;

	logic [7:0] access_cnt;
	logic [5:0] win_tag;
	logic       hit;
	logic       cnt_full;

	// framebuffer moves to $e8 under steroids
	assign win_tag  = cfg_i.steroids ? VIKING_HI_BASE : VIKING_ST_BASE;
	assign hit      = bus_i.mhz8_en1 & ~bus_i.as_n & cfg_i.viking_enable &
	                  (bus_i.mbus_a[23:18] == win_tag);
	assign cnt_full = (access_cnt == VIKING_ACCESS_MAX);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			access_cnt      <= 8'd0;
			viking_active_o <= 1'b0;
		end else begin
			if (hit && !cnt_full)
				access_cnt <= access_cnt + 8'd1; // saturates at max
			// sticky, probes alone never get here
			viking_active_o <= viking_active_o | cnt_full;
		end
	end

endmodule

// ==== design/st_ram_window.sv ====
// chipset ram cycle start detection gated by the ram size and viking windows
`timescale 1ns/1ps

module st_ram_window (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  st_mem_pkg::st_cfg_t   cfg_i,
	input  st_mem_pkg::chip_bus_t bus_i,
	output logic                  ram_oe_o,
	output logic                  ram_we_o
);

	import st_mem_pkg::*;

	logic  ras_n_d;
	logic  ras_fall;
	logic  size_ok;
	logic  viking_ok;
	logic  ram_en;
	addr_t a;

	assign a = bus_i.ram_a;

	// previous ras_n, held high in reset so no fake edge
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			ras_n_d <= 1'b1;
		else
			ras_n_d <= bus_i.ras_n;
	end

	assign ras_fall = ras_n_d & ~bus_i.ras_n;

	// configured ram size limit
	always_comb begin
		case (cfg_i.mem_size)
			MEM_512K: size_ok = (a[23:19] == 5'b00000);
			MEM_1M:   size_ok = (a[23:20] == 4'b0000);
			MEM_2M:   size_ok = (a[23:21] == 3'b000);
			MEM_4M:   size_ok = (a[23:22] == 2'b00);
			MEM_8M:   size_ok = ~a[23];
			MEM_14M:  size_ok = ~(a[23] & a[22]); // no 110 or 111
			default:  size_ok = 1'b0;             // unused codes
		endcase
	end

	// viking video ram lives outside the normal size limit
	assign viking_ok = cfg_i.viking_enable & (cfg_i.steroids ?
	                   (a[23:19] == VIKING_HI_WIN) :
	                   (a[23:18] == VIKING_ST_BASE));

	assign ram_en = size_ok | viking_ok;

	// address zero reads are skipped
	assign ram_oe_o = ras_fall & bus_i.we_n & (|a) & ram_en;
	assign ram_we_o = ras_fall & ~bus_i.we_n & ram_en;

endmodule

// ==== design/st_sdram_mux.sv ====
// sdram request source selection per bus slot and rom address remap
`timescale 1ns/1ps

module st_sdram_mux (
	input  st_mem_pkg::chip_bus_t  bus_i,
	input  st_mem_pkg::upload_t    upload_i,
	input  st_mem_pkg::addr_t      viking_vaddr_i,
	input  logic                   viking_read_i,
	input  logic                   viking_active_i,
	input  logic                   data_wr_i,
	input  logic                   tos192k_i,
	input  logic                   ram_oe_i,
	input  logic                   ram_we_i,
	output st_mem_pkg::sdram_req_t sdram_req_o,
	output logic                   rom_oe_o,
	output st_mem_pkg::addr_t      rom_addr_o
);

	import st_mem_pkg::*;

	logic upload_sel; // io controller owns the cpu slot
	logic viking_sel; // video fetch in the viking slot

	assign upload_sel = (bus_i.bus_cycle == CYC_CPU) & upload_i.download;
	assign viking_sel = (bus_i.bus_cycle == CYC_VIKING) & viking_active_i & viking_read_i;

	always_comb begin
		// chipset by default
		sdram_req_o.addr = bus_i.ram_a;
		sdram_req_o.uds  = bus_i.uds;
		sdram_req_o.lds  = bus_i.lds;
		sdram_req_o.we   = ram_we_i;
		sdram_req_o.oe   = ram_oe_i;
		if (upload_sel) begin
			sdram_req_o.addr = upload_i.addr;
			sdram_req_o.uds  = 1'b1; // always full words
			sdram_req_o.lds  = 1'b1;
			sdram_req_o.we   = data_wr_i;
			sdram_req_o.oe   = 1'b0;
		end else if (viking_sel) begin
			sdram_req_o.addr = viking_vaddr_i;
			sdram_req_o.we   = 1'b0;
			sdram_req_o.oe   = 1'b1;
		end
	end

	// write data follows the download flag, not the slot
	assign sdram_req_o.din = upload_i.download ? upload_i.data : bus_i.ram_din;

	assign rom_oe_o = ~bus_i.rom_n;

	// tos area maps to $fc or $e0 in sdram
	assign rom_addr_o = bus_i.rom2_n ? bus_i.mbus_a :
	                    {(tos192k_i ? ROM_F_PREFIX : ROM_E_PREFIX), bus_i.mbus_a[17:1]};

endmodule

// ==== design/st_mem_top.sv ====
// top level of the st sdram request path
`timescale 1ns/1ps

module st_mem_top (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  logic [31:0]            system_ctrl_i,
	input  st_mem_pkg::chip_bus_t  bus_i,
	input  st_mem_pkg::upload_t    upload_i,
	input  st_mem_pkg::addr_t      viking_vaddr_i,
	input  logic                   viking_read_i,
	output st_mem_pkg::sdram_req_t sdram_req_o,
	output logic                   rom_oe_o,
	output st_mem_pkg::addr_t      rom_addr_o,
	output logic                   viking_active_o,
	output logic                   tos192k_o
);

	import st_mem_pkg::*;

	st_cfg_t cfg;
	logic    data_wr;  // upload write pulse
	logic    ram_oe;   // already window gated
	logic    ram_we;

	st_cfg_decode cfg_decode_i (
		.system_ctrl_i (system_ctrl_i),
		.cfg_o         (cfg)
	);

	st_upload_ctrl upload_ctrl_i (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.upload_i    (upload_i),
		.bus_cycle_i (bus_i.bus_cycle),
		.mhz8_en1_i  (bus_i.mhz8_en1),
		.data_wr_o   (data_wr),
		.tos192k_o   (tos192k_o)
	);

	st_viking_detect viking_detect_i (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.cfg_i           (cfg),
		.bus_i           (bus_i),
		.viking_active_o (viking_active_o)
	);

	st_ram_window ram_window_i (
		.clk_32   (clk_32),
		.xsint    (xsint),
		.cfg_i    (cfg),
		.bus_i    (bus_i),
		.ram_oe_o (ram_oe),
		.ram_we_o (ram_we)
	);

	st_sdram_mux sdram_mux_i (
		.bus_i           (bus_i),
		.upload_i        (upload_i),
		.viking_vaddr_i  (viking_vaddr_i),
		.viking_read_i   (viking_read_i),
		.viking_active_i (viking_active_o),
		.data_wr_i       (data_wr),
		.tos192k_i       (tos192k_o),
		.ram_oe_i        (ram_oe),
		.ram_we_i        (ram_we),
		.sdram_req_o     (sdram_req_o),
		.rom_oe_o        (rom_oe_o),
		.rom_addr_o      (rom_addr_o)
	);

endmodule

// ==== tb/st_mem_asserts.sv ====
// bound assertions: request exclusivity, write pulse width, sticky viking flag
`timescale 1ns/1ps

module st_mem_asserts (
	input logic                   clk_32,
	input logic                   xsint,
	input st_mem_pkg::sdram_req_t sdram_req_o,
	input logic                   data_wr,
	input logic                   viking_active_o
);

	import st_mem_pkg::*;

	// read and write never in the same cycle
	assert property (@(posedge clk_32) disable iff (!xsint)
		!(sdram_req_o.we && sdram_req_o.oe))
		else $error("sdram we and oe high together");

	assert property (@(posedge clk_32) disable iff (!xsint)
		data_wr |=> !data_wr) // one clock only
		else $error("upload write pulse longer than one cycle");

	// only reset clears it
	assert property (@(posedge clk_32) disable iff (!xsint)
		viking_active_o |=> viking_active_o)
		else $error("viking_active_o fell without reset");

endmodule

bind st_mem_top st_mem_asserts asserts_i (
	.clk_32          (clk_32),
	.xsint           (xsint),
	.sdram_req_o     (sdram_req_o),
	.data_wr         (data_wr),
	.viking_active_o (viking_active_o)
);

// ==== tb/tb_st_mem.sv ====
// st_mem_top testbench with stimulus, reference model, compare process and report
`timescale 1ns/1ps

module tb_st_mem;

	import st_mem_pkg::*;

	logic        clk_32;
	logic        xsint;
	logic [31:0] ctrl;
	chip_bus_t   bus;
	upload_t     up;
	addr_t       vaddr;
	logic        vread;
	sdram_req_t  req;
	logic        rom_oe;
	addr_t       rom_addr;
	logic        vact;
	logic        tos192k;

	int          errors;
	int          timeouts;
	logic [31:0] lfsr = 32'hf0740a58;

	// model copies of the dut registers
	logic       m_ras_d;
	logic       m_strobe_d;
	logic       m_data_wr;
	logic       m_tos192k;
	logic       m_active;
	logic [7:0] m_cnt;

	st_mem_top dut_i (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.system_ctrl_i   (ctrl),
		.bus_i           (bus),
		.upload_i        (up),
		.viking_vaddr_i  (vaddr),
		.viking_read_i   (vread),
		.sdram_req_o     (req),
		.rom_oe_o        (rom_oe),
		.rom_addr_o      (rom_addr),
		.viking_active_o (vact),
		.tos192k_o       (tos192k)
	);

	initial begin
		clk_32 = 1'b0;
		forever #2 clk_32 = ~clk_32; // 4 ns period
	end

	// fibonacci lfsr stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic steroids_on();
		return ctrl[23] & ctrl[24];
	endfunction

	function automatic logic viking_en();
		return (ctrl[28] && ctrl[3:1] <= 3'd4) || steroids_on();
	endfunction

	// expected sdram request from the memory map rules
	function automatic sdram_req_t ref_req();
		sdram_req_t e;
		logic       in_size, in_vik, ras_fall;
		addr_t      a;
		a = bus.ram_a;
		case (ctrl[3:1])
			3'd0: in_size = a < 23'h040000;  // 512k
			3'd1: in_size = a < 23'h080000;
			3'd2: in_size = a < 23'h100000;
			3'd3: in_size = a < 23'h200000;
			3'd4: in_size = a < 23'h400000;  // 8M
			3'd5: in_size = a < 23'h600000;  // 14M stops below $c00000
			default: in_size = 1'b0;
		endcase
		in_vik   = viking_en() && (steroids_on() ? a[23:19] == 5'b11101 : a[23:18] == 6'h30);
		ras_fall = m_ras_d && !bus.ras_n;
		e.addr = a;
		e.uds  = bus.uds;
		e.lds  = bus.lds;
		e.we   = ras_fall && !bus.we_n && (in_size || in_vik);
		e.oe   = ras_fall && bus.we_n && a != '0 && (in_size || in_vik);
		e.din  = up.download ? up.data : bus.ram_din;
		if (bus.bus_cycle == CYC_CPU && up.download) begin
			e.addr = up.addr;
			e.uds  = 1'b1;
			e.lds  = 1'b1;
			e.we   = m_data_wr;
			e.oe   = 1'b0;
		end else if (bus.bus_cycle == CYC_VIKING && m_active && vread) begin
			e.addr = vaddr;
			e.we   = 1'b0;
			e.oe   = 1'b1;
		end
		return e;
	endfunction

	function automatic addr_t ref_rom_addr();
		if (bus.rom2_n)
			return bus.mbus_a;
		return {(m_tos192k ? 6'b111111 : 6'b111000), bus.mbus_a[17:1]};
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// compare at the falling edge and step the model as the next rising edge would
	always @(negedge clk_32) begin
		if (!xsint) begin
			m_ras_d = 1'b1;
			m_strobe_d = 1'b0;
			m_data_wr = 1'b0;
			m_tos192k = 1'b0;
			m_active = 1'b0;
			m_cnt = 8'd0;
		end else begin
			check("sdram_req_o", 64'(req), 64'(ref_req()));
			check("rom_oe_o", 64'(rom_oe), 64'(!bus.rom_n));
			check("rom_addr_o", 64'(rom_addr), 64'(ref_rom_addr()));
			check("viking_active_o", 64'(vact), 64'(m_active));
			check("tos192k_o", 64'(tos192k), 64'(m_tos192k));
			m_ras_d   = bus.ras_n;
			m_data_wr = 1'b0;
			if (bus.bus_cycle == CYC_CPU_PRE && bus.mhz8_en1) begin
				m_data_wr  = up.strobe != m_strobe_d; // toggle seen
				m_strobe_d = up.strobe;
			end
			if (up.download && up.addr[23:18] == 6'h3f)
				m_tos192k = 1'b1;
			else if (up.download && up.addr[23:20] == 4'he)
				m_tos192k = 1'b0;
			m_active = m_active || m_cnt == 8'd255;
			if (bus.mhz8_en1 && !bus.as_n && viking_en() && m_cnt != 8'd255 &&
			    bus.mbus_a[23:18] == (steroids_on() ? 6'h3a : 6'h30))
				m_cnt = m_cnt + 8'd1;
		end
	end

	function automatic chip_bus_t idle_bus();
		chip_bus_t b;
		b = '0;
		b.ras_n = 1'b1;
		b.we_n = 1'b1;
		b.rom_n = 1'b1;
		b.rom2_n = 1'b1;
		b.as_n = 1'b1;
		b.bus_cycle = CYC_OTHER;
		return b;
	endfunction

	task automatic apply_reset();
		@(posedge clk_32);
		xsint <= 1'b0;
		repeat (10) @(posedge clk_32);
		xsint <= 1'b1;
	endtask

	// one chipset ram cycle with ras low for a single clock
	task automatic ram_cycle(input addr_t a, input logic we_n);
		chip_bus_t b;
		b = idle_bus();
		b.ras_n = 1'b0;
		b.we_n = we_n;
		b.ram_a = a;
		b.uds = 1'(take_bits(1));
		b.lds = 1'(take_bits(1));
		b.ram_din = word_t'(take_bits(16));
		@(posedge clk_32);
		bus <= b;
		@(posedge clk_32);
		bus <= idle_bus();
	endtask

	// strobe toggle in the pre slot and the write in the cpu slot
	task automatic upload_word(input addr_t a);
		chip_bus_t b;
		upload_t   u;
		b = idle_bus();
		b.bus_cycle = CYC_CPU_PRE;
		b.mhz8_en1 = 1'b1;
		u = up;
		u.strobe = ~up.strobe;
		u.download = 1'b1;
		u.addr = a;
		u.data = word_t'(take_bits(16));
		@(posedge clk_32);
		bus <= b;
		up <= u;
		b.bus_cycle = CYC_CPU;
		b.mhz8_en1 = 1'b0;
		@(posedge clk_32);
		bus <= b;
		@(posedge clk_32);
		bus <= idle_bus();
	endtask

	task automatic rom_access(input logic rom2_n);
		chip_bus_t b;
		b = idle_bus();
		b.rom_n = 1'b0;
		b.rom2_n = rom2_n;
		b.mbus_a = addr_t'(take_bits(23));
		@(posedge clk_32);
		bus <= b;
	endtask

	// viking slot fetches, read request alternating
	task automatic viking_fetch(input int cycles);
		chip_bus_t b;
		b = idle_bus();
		b.bus_cycle = CYC_VIKING;
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk_32);
			bus <= b;
			vread <= ~i[0];
			vaddr <= addr_t'(take_bits(23));
		end
		@(posedge clk_32);
		bus <= idle_bus();
		vread <= 1'b0;
	endtask

	// qualifying accesses and a bounded wait for the flag
	task automatic viking_run(input logic [5:0] tag);
		chip_bus_t b;
		int        n;
		viking_fetch(4); // still chipset before activation
		b = idle_bus();
		b.mhz8_en1 = 1'b1;
		b.as_n = 1'b0;
		repeat (255) begin
			b.mbus_a = {tag, 17'(take_bits(17))};
			@(posedge clk_32);
			bus <= b;
		end
		@(posedge clk_32);
		bus <= idle_bus();
		n = 0;
		while (!vact && n < 20) begin
			@(posedge clk_32);
			n++;
		end
		if (!vact) begin
			timeouts++;
			$display("timeout: viking_active_o did not rise after the access run");
		end
		viking_fetch(6);
	endtask

	initial begin
		errors = 0;
		timeouts = 0;
		xsint = 1'b0;
		ctrl = '0;
		bus = idle_bus();
		up = '0;
		vaddr = '0;
		vread = 1'b0;
		repeat (10) @(posedge clk_32);
		xsint <= 1'b1;
		// ram size windows
		for (int s = 0; s < 6; s++) begin
			@(posedge clk_32);
			ctrl <= {28'd0, s[2:0], 1'b0};
			ram_cycle('0, 1'b1); // zero read
			repeat (24)
				ram_cycle(addr_t'(take_bits(23)), 1'(take_bits(1)));
		end
		// uploads and tos detection
		for (int i = 0; i < 8; i++)
			upload_word(addr_t'(take_bits(23)));
		upload_word({6'h3f, 17'h00010});
		rom_access(1'b0);
		rom_access(1'b1);
		upload_word({4'he, 19'h00020});
		rom_access(1'b0);
		@(posedge clk_32);
		up.download <= 1'b0;
		bus <= idle_bus();
		// viking in st mode and then under steroids
		@(posedge clk_32);
		ctrl <= 32'h1000_0008;
		viking_run(6'h30);
		apply_reset();
		ctrl <= 32'h0180_0000;
		viking_run(6'h3a);
		// viking ram windows above the size
		repeat (8)
			ram_cycle({5'b11101, 18'(take_bits(18))}, 1'(take_bits(1)));
		@(posedge clk_32);
		ctrl <= 32'h1000_0000;
		repeat (8)
			ram_cycle({6'h30, 17'(take_bits(17))}, 1'(take_bits(1)));
		@(posedge clk_32);
		ctrl <= 32'h1000_000a; // 14M asks for viking and is refused
		repeat (8)
			ram_cycle({6'h30, 17'(take_bits(17))}, 1'(take_bits(1)));
		repeat (4) @(posedge clk_32);
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== sim.f ====
design/st_mem_pkg.sv
design/st_cfg_decode.sv
design/st_upload_ctrl.sv
design/st_viking_detect.sv
design/st_ram_window.sv
design/st_sdram_mux.sv
design/st_mem_top.sv
tb/st_mem_asserts.sv
tb/tb_st_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -j 0
TOP       ?= tb_st_mem
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
